// ==== Makefile ====
# Verilator flow for the hello register block

VERILATOR ?= verilator
FILELIST  ?= sources.f
TOP       ?= tb_cl_hello
RTL_TOP   ?= cl_hello_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASS" $(LOG); then echo "Simulation ended early"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== sources.f ====
+incdir+verilog
verilog/hello_pkg.sv
verilog/ocl_access_fsm.sv
verilog/hello_regs.sv
verilog/tick_counter.sv
verilog/vled_mask.sv
verilog/cl_hello_top.sv
test/tb_clock_gen.sv
test/tb_cl_hello.sv

// ==== test/tb_cl_hello.sv ====
// Directed tests for cl_hello_top with inputs changed 1 ns after the edge and a 4000-cycle limit
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module tb_cl_hello;

  // About 70 host accesses of up to 10 cycles each, plus the counter waits
  localparam int TIMEOUT_CYCLES  = 4000;
  // Wait for a ready before the request counts as stuck
  localparam int HANDSHAKE_LIMIT = 32;

  logic                     clk_main_a0;
  logic                     rst_main_n_sync;
  hello_pkg::ocl_wr_req_t   wr_req;
  logic                     wr_ready;
  logic                     bvalid;
  logic                     bready;
  hello_pkg::ocl_rd_req_t   rd_req;
  logic                     rd_ready;
  hello_pkg::ocl_rd_rsp_t   rd_rsp;
  logic                     rready;
  logic [`HELLO_VLED_W-1:0] vdip;
  logic [`HELLO_VLED_W-1:0] vled;

  integer seed         = 32'h172a_98d4;
  int     cycle_cnt    = 0;
  int     mismatch_cnt = 0;
  int     protocol_cnt = 0;

  tb_clock_gen u_clock_gen (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync)
  );

  cl_hello_top UUT (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_req          (wr_req),
    .wr_ready        (wr_ready),
    .bvalid          (bvalid),
    .bready          (bready),
    .rd_req          (rd_req),
    .rd_ready        (rd_ready),
    .rd_rsp          (rd_rsp),
    .rready          (rready),
    .vdip            (vdip),
    .vled            (vled)
  );

  // Cycle count doubles as the elapsed-time reference
  always @(posedge clk_main_a0) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  // --------------------------------------------------------------------------
  // Compare and report helpers
  // --------------------------------------------------------------------------
  task automatic check_data(input string name, input logic [`HELLO_DATA_W-1:0] exp,
                            input logic [`HELLO_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected 0x%08h actual 0x%08h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_vled(input string name, input logic [`HELLO_VLED_W-1:0] exp,
                            input logic [`HELLO_VLED_W-1:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected 0x%04h actual 0x%04h", name, exp, act);
      mismatch_cnt++;
    end
  endtask

  task automatic check_status(input string name, input hello_pkg::cnt_status_t exp,
                              input hello_pkg::cnt_status_t act);
    if (act !== exp) begin
      $display("Mismatch %s: expected count 0x%04h flag %0b actual count 0x%04h flag %0b",
               name, exp.count, exp.ge_watermark, act.count, act.ge_watermark);
      mismatch_cnt++;
    end
  endtask

  task automatic report_protocol_error(input string msg);
    $display("Error: %s", msg);
    protocol_cnt++;
  endtask

  // Byte i of the host view is byte 3-i of the register
  function automatic logic [31:0] byte_reverse(input logic [31:0] v);
    logic [31:0] r;
    for (int i = 0; i < 4; i++) begin
      r[8*i +: 8] = v[8*(3-i) +: 8];
    end
    return r;
  endfunction

  // Back-pressure of 1 to 4 cycles
  function automatic int pick_delay();
    logic [31:0] r;
    r = $random(seed);
    pick_delay = 1 + int'(r[1:0]);
  endfunction

  // --------------------------------------------------------------------------
  // Host handshake tasks entered and left 1 ns after an edge
  // --------------------------------------------------------------------------
  task automatic await_ready(input string name, input logic is_write);
    int waited;
    waited = 0;
    while ((is_write ? !wr_ready : !rd_ready) && waited < HANDSHAKE_LIMIT) begin
      @(posedge clk_main_a0);
      #1;
      waited++;
    end
    if (is_write ? !wr_ready : !rd_ready) begin
      report_protocol_error({name, ": request was never accepted by the DUT"});
    end
  endtask

  task automatic take_bresp(input string name);
    int delay;
    delay = pick_delay();
    if (!bvalid) begin
      report_protocol_error({name, ": write response missing the cycle after accept"});
    end
    // Hold off bready and watch bvalid stay up
    repeat (delay) begin
      @(posedge clk_main_a0);
      #1;
      if (!bvalid) begin
        report_protocol_error({name, ": write response dropped before bready"});
      end
    end
    bready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    bready = 1'b0;
  endtask

  task automatic take_rresp(input string name, output logic [`HELLO_DATA_W-1:0] data);
    int                       delay;
    logic [`HELLO_DATA_W-1:0] held;
    delay = pick_delay();
    if (!rd_rsp.valid) begin
      report_protocol_error({name, ": read response missing the cycle after accept"});
    end
    held = rd_rsp.data;
    repeat (delay) begin
      @(posedge clk_main_a0);
      #1;
      if (!rd_rsp.valid || rd_rsp.data !== held) begin
        report_protocol_error({name, ": read response changed before rready"});
      end
    end
    data   = rd_rsp.data;
    rready = 1'b1;
    @(posedge clk_main_a0);
    #1;
    rready = 1'b0;
  endtask

  task automatic host_write(input string name, input logic [`HELLO_ADDR_W-1:0] addr,
                            input logic [`HELLO_DATA_W-1:0] data);
    wr_req = '{valid: 1'b1, addr: addr, data: data};
    await_ready(name, 1'b1);
    @(posedge clk_main_a0);
    #1;
    wr_req.valid = 1'b0;
    take_bresp(name);
  endtask

  task automatic host_read(input string name, input logic [`HELLO_ADDR_W-1:0] addr,
                           output logic [`HELLO_DATA_W-1:0] data);
    rd_req = '{valid: 1'b1, addr: addr};
    await_ready(name, 1'b0);
    @(posedge clk_main_a0);
    #1;
    rd_req.valid = 1'b0;
    take_rresp(name, data);
  endtask

  // Count in bits 15:0, flag in bit 16
  task automatic read_status(input string name, output hello_pkg::cnt_status_t st);
    logic [`HELLO_DATA_W-1:0] d;
    host_read(name, hello_pkg::CNT_STATUS, d);
    st = '{count: d[15:0], ge_watermark: d[16]};
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_main_a0);
    #1;
  endtask

  // --------------------------------------------------------------------------
  // Directed tests
  // --------------------------------------------------------------------------
  task automatic test_reset_values();
    logic [31:0]            d;
    hello_pkg::cnt_status_t st;
    hello_pkg::cnt_status_t exp;
    host_read("reset_hello", hello_pkg::HELLO, d);
    check_data("reset_hello", 32'h0, d);
    host_read("reset_vled", hello_pkg::VLED, d);
    check_data("reset_vled", 32'h0, d);
    // Count 0 against watermark 0 sets the flag
    exp = '{count: 16'h0000, ge_watermark: 1'b1};
    read_status("reset_status", st);
    check_status("reset_status", exp, st);
    host_read("reset_version", hello_pkg::VERSION, d);
    check_data("reset_version", 32'hee_ee_ee_00, d);
    host_read("unmapped", 32'h0000_0600, d);
    check_data("unmapped", 32'hdead_beef, d);
  endtask

  task automatic test_hello_swap();
    logic [31:0] v;
    logic [31:0] d;
    for (int i = 0; i < 4; i++) begin
      v = $random(seed);
      host_write("hello_swap", hello_pkg::HELLO, v);
      host_read("hello_swap", hello_pkg::HELLO, d);
      check_data("hello_swap", byte_reverse(v), d);
      host_read("vled_read", hello_pkg::VLED, d);
      check_data("vled_read", {16'h0000, v[15:0]}, d);
    end
    // Version is read-only
    v = $random(seed);
    host_write("version_ro", hello_pkg::VERSION, v);
    host_read("version_ro", hello_pkg::VERSION, d);
    check_data("version_ro", 32'hee_ee_ee_00, d);
  endtask

  task automatic test_vled_mask();
    logic [31:0] v;
    logic [31:0] r;
    for (int i = 0; i < 3; i++) begin
      v = $random(seed);
      r = $random(seed);
      host_write("vled_mask", hello_pkg::HELLO, v);
      vdip = r[15:0];
      // Switch path is three flops deep
      wait_cycles(5);
      check_vled("vled_mask", v[15:0] & r[15:0], vled);
    end
  endtask

  task automatic test_counter_static();
    logic [31:0]            d;
    logic [31:0]            r;
    logic [15:0]            lv;
    logic [15:0]            wm;
    hello_pkg::cnt_status_t st;
    hello_pkg::cnt_status_t exp;
    r  = $random(seed);
    lv = r[15:0] & 16'h7fff;
    wm = r[31:16];
    host_write("tick_value_rb", hello_pkg::TICK_VALUE, {24'h0, r[23:16]});
    host_read("tick_value_rb", hello_pkg::TICK_VALUE, d);
    check_data("tick_value_rb", {24'h0, r[23:16]}, d);
    host_write("load_value_rb", hello_pkg::LOAD_VALUE, {16'h0, lv});
    host_read("load_value_rb", hello_pkg::LOAD_VALUE, d);
    check_data("load_value_rb", {16'h0, lv}, d);
    host_write("watermark_rb", hello_pkg::WATERMARK, {16'h0, wm});
    host_read("watermark_rb", hello_pkg::WATERMARK, d);
    check_data("watermark_rb", {16'h0, wm}, d);
    // Load while disabled
    host_write("cnt_load", hello_pkg::CNT_CTRL, 32'h8);
    exp = '{count: lv, ge_watermark: (lv >= wm)};
    read_status("cnt_load", st);
    check_status("cnt_load", exp, st);
    // Watermark just above, then equal
    host_write("wm_above", hello_pkg::WATERMARK, {16'h0, lv + 16'h1});
    exp.ge_watermark = 1'b0;
    read_status("wm_above", st);
    check_status("wm_above", exp, st);
    host_write("wm_equal", hello_pkg::WATERMARK, {16'h0, lv});
    exp.ge_watermark = 1'b1;
    read_status("wm_equal", st);
    check_status("wm_equal", exp, st);
    host_write("cnt_clear", hello_pkg::CNT_CTRL, 32'h4);
    exp = '{count: 16'h0000, ge_watermark: (lv == 16'h0000)};
    read_status("cnt_clear", st);
    check_status("cnt_clear", exp, st);
    // Pulse bits never read back
    host_read("ctrl_rb", hello_pkg::CNT_CTRL, d);
    check_data("ctrl_rb", 32'h0, d);
  endtask

  task automatic test_counter_run();
    hello_pkg::cnt_status_t st1;
    hello_pkg::cnt_status_t st2;
    hello_pkg::cnt_status_t exp;
    int                     start_cyc;
    int                     elapsed;
    host_write("cnt_run", hello_pkg::CNT_CTRL, 32'h4);
    host_write("cnt_run", hello_pkg::TICK_VALUE, 32'h3);
    start_cyc = cycle_cnt;
    host_write("cnt_run", hello_pkg::CNT_CTRL, 32'h1);
    wait_cycles(80);
    host_write("cnt_run", hello_pkg::CNT_CTRL, 32'h0);
    elapsed = cycle_cnt - start_cyc;
    read_status("cnt_frozen", st1);
    read_status("cnt_frozen", st2);
    check_status("cnt_frozen", st1, st2);
    // One tick per 4 enabled cycles at most
    if (st1.count == 16'h0000 || int'(st1.count) > elapsed / 4) begin
      $display("Mismatch cnt_run: expected count 1..%0d actual %0d", elapsed / 4, st1.count);
      mismatch_cnt++;
    end
    // One-shot from 0xfffe with one tick per cycle
    host_write("oneshot", hello_pkg::WATERMARK, 32'h8000);
    host_write("oneshot", hello_pkg::TICK_VALUE, 32'h0);
    host_write("oneshot", hello_pkg::LOAD_VALUE, 32'hfffe);
    host_write("oneshot", hello_pkg::CNT_CTRL, 32'ha);
    host_write("oneshot", hello_pkg::CNT_CTRL, 32'h3);
    wait_cycles(20);
    host_write("oneshot", hello_pkg::CNT_CTRL, 32'h2);
    exp = '{count: 16'hffff, ge_watermark: 1'b1};
    read_status("oneshot_sat", st1);
    check_status("oneshot_sat", exp, st1);
    // Same run without one-shot has to wrap
    host_write("wrap", hello_pkg::CNT_CTRL, 32'h8);
    host_write("wrap", hello_pkg::CNT_CTRL, 32'h1);
    wait_cycles(20);
    host_write("wrap", hello_pkg::CNT_CTRL, 32'h0);
    read_status("wrap", st1);
    if (st1.count >= 16'hfffe) begin
      $display("Mismatch wrap: expected count below 0xfffe actual 0x%04h", st1.count);
      mismatch_cnt++;
    end
  endtask

  task automatic test_write_read_race();
    logic [31:0] v;
    logic [31:0] d;
    v      = $random(seed);
    wr_req = '{valid: 1'b1, addr: hello_pkg::HELLO, data: v};
    rd_req = '{valid: 1'b1, addr: hello_pkg::HELLO};
    // Let the readies settle on the new requests
    #1;
    if (!wr_ready || rd_ready) begin
      report_protocol_error("race: write was not taken ahead of the simultaneous read");
    end
    @(posedge clk_main_a0);
    #1;
    wr_req.valid = 1'b0;
    if (rd_rsp.valid) begin
      report_protocol_error("race: read response raised while the write was in flight");
    end
    take_bresp("race_write");
    // Read still pending until the sequencer is back in IDLE
    await_ready("race_read", 1'b0);
    @(posedge clk_main_a0);
    #1;
    rd_req.valid = 1'b0;
    take_rresp("race_read", d);
    check_data("race_read", byte_reverse(v), d);
  endtask

  // --------------------------------------------------------------------------
  // Sequence and final report
  // --------------------------------------------------------------------------
  initial begin
    wr_req = '0;
    rd_req = '0;
    bready = 1'b0;
    rready = 1'b0;
    vdip   = '0;
    @(posedge rst_main_n_sync);
    @(posedge clk_main_a0);
    #1;
    test_reset_values();
    test_hello_swap();
    test_vled_mask();
    test_counter_static();
    test_counter_run();
    test_write_read_race();
    $display("Errors: %0d mismatches, %0d handshake failures", mismatch_cnt, protocol_cnt);
    if (mismatch_cnt + protocol_cnt == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== test/tb_clock_gen.sv ====
// Free-running 4 ns clock, reset held low for the first 4 rising edges and released 1 ns after
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
  output logic clk_main_a0,
  output logic rst_main_n_sync
);

  // Half period of 2 ns
  initial begin
    clk_main_a0 = 1'b0;
    forever #2 clk_main_a0 = ~clk_main_a0;
  end

  // Release away from the edge, like the other inputs
  initial begin
    rst_main_n_sync = 1'b0;
    repeat (4) @(posedge clk_main_a0);
    #1;
    rst_main_n_sync = 1'b1;
  end

endmodule

`default_nettype wire

// ==== verilog/cl_hello_top.sv ====
// Host requests are held until accepted, and only one access is in flight at any time
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module cl_hello_top (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  input  wire hello_pkg::ocl_wr_req_t   wr_req,
  output logic                          wr_ready,
  output logic                          bvalid,
  input  wire logic                     bready,
  input  wire hello_pkg::ocl_rd_req_t   rd_req,
  output logic                          rd_ready,
  output hello_pkg::ocl_rd_rsp_t        rd_rsp,
  input  wire logic                     rready,
  input  wire logic [`HELLO_VLED_W-1:0] vdip,
  output logic [`HELLO_VLED_W-1:0]      vled
);

  // --------------------------------------------------------------------------
  // Internal paths
  // --------------------------------------------------------------------------
  hello_pkg::reg_write_t    reg_write;
  logic [`HELLO_ADDR_W-1:0] rd_addr;
  logic [`HELLO_DATA_W-1:0] rd_data;
  hello_pkg::cnt_ctrl_t     cnt_ctrl;
  hello_pkg::cnt_status_t   cnt_status;
  logic [`HELLO_VLED_W-1:0] vled_src;

  // Host access sequencer
  ocl_access_fsm u_access_fsm (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .wr_req          (wr_req),
    .wr_ready        (wr_ready),
    .bvalid          (bvalid),
    .bready          (bready),
    .rd_req          (rd_req),
    .rd_ready        (rd_ready),
    .rd_rsp          (rd_rsp),
    .rready          (rready),
    .reg_write       (reg_write),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data)
  );

  // Register bank
  hello_regs u_regs (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .reg_write       (reg_write),
    .rd_addr         (rd_addr),
    .rd_data         (rd_data),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status),
    .vled_src        (vled_src)
  );

  // Prescaled event counter
  tick_counter u_tick_counter (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .cnt_ctrl        (cnt_ctrl),
    .cnt_status      (cnt_status)
  );

  // LED output behind the DIP mask
  vled_mask u_vled_mask (
    .clk_main_a0     (clk_main_a0),
    .rst_main_n_sync (rst_main_n_sync),
    .vled_src        (vled_src),
    .vdip            (vdip),
    .vled            (vled)
  );

endmodule

`default_nettype wire

// ==== verilog/hello_defs.svh ====
// Bus and counter widths are fixed by the register map and must not be changed on their own
`ifndef HELLO_DEFS_SVH
`define HELLO_DEFS_SVH

// ---------------------------------------------------------------------------
// Host access widths
// ---------------------------------------------------------------------------

// Byte address carried with every host request
`define HELLO_ADDR_W 32

// Register data, one full word per access
`define HELLO_DATA_W 32

// ---------------------------------------------------------------------------
// Virtual LED and DIP widths
// ---------------------------------------------------------------------------

// One bit per LED and per switch
`define HELLO_VLED_W 16

// ---------------------------------------------------------------------------
// Event counter widths
// ---------------------------------------------------------------------------

// Prescaler and its tick value
`define HELLO_TICK_W 8

// Event count, load value and watermark
`define HELLO_CNT_W 16

// ---------------------------------------------------------------------------
// Fixed read values
// ---------------------------------------------------------------------------

// Returned by the version register
`define HELLO_VERSION 32'hee_ee_ee_00

// Fill for any offset outside the map
`define HELLO_UNIMPL_VALUE 32'hdead_beef

`endif

// ==== verilog/hello_pkg.sv ====
// Shared types for the hello register block, sized from the macros in the defs header
`default_nettype none

`include "hello_defs.svh"

package hello_pkg;

  // Register offsets inside the host window
  typedef enum logic [`HELLO_ADDR_W-1:0] {
    HELLO      = 32'h0000_0500,
    VLED       = 32'h0000_0504,
    CNT_CTRL   = 32'h0000_0508,
    TICK_VALUE = 32'h0000_050C,
    LOAD_VALUE = 32'h0000_0510,
    WATERMARK  = 32'h0000_0514,
    CNT_STATUS = 32'h0000_0518,
    VERSION    = 32'h0000_051C
  } reg_addr_e;

  // CNT_CTRL bit positions, clear and load self-clear
  localparam int unsigned CTRL_ENABLE_BIT  = 0;
  localparam int unsigned CTRL_ONESHOT_BIT = 1;
  localparam int unsigned CTRL_CLEAR_BIT   = 2;
  localparam int unsigned CTRL_LOAD_BIT    = 3;

  // Host access sequencer states
  typedef enum logic [1:0] {
    IDLE,
    WRITE_RESP,
    READ_RESP
  } access_state_e;

  // Write request, address travels with its data
  typedef struct packed {
    logic                     valid;
    logic [`HELLO_ADDR_W-1:0] addr;
    logic [`HELLO_DATA_W-1:0] data;
  } ocl_wr_req_t;

  // Read request
  typedef struct packed {
    logic                     valid;
    logic [`HELLO_ADDR_W-1:0] addr;
  } ocl_rd_req_t;

  // Read response
  typedef struct packed {
    logic                     valid;
    logic [`HELLO_DATA_W-1:0] data;
  } ocl_rd_rsp_t;

  // One-cycle write from the sequencer into the bank
  typedef struct packed {
    logic                     strobe;
    logic [`HELLO_ADDR_W-1:0] addr;
    logic [`HELLO_DATA_W-1:0] data;
  } reg_write_t;

  // Counter controls, clear and load are single-cycle pulses
  typedef struct packed {
    logic                     enable;
    logic                     oneshot;
    logic                     clear;
    logic                     load;
    logic [`HELLO_TICK_W-1:0] tick_value;
    logic [`HELLO_CNT_W-1:0]  load_value;
    logic [`HELLO_CNT_W-1:0]  watermark;
  } cnt_ctrl_t;

  // Counter status back to the bank
  typedef struct packed {
    logic [`HELLO_CNT_W-1:0] count;
    logic                    ge_watermark;
  } cnt_status_t;

endpackage

`default_nettype wire

// ==== verilog/hello_regs.sv ====
// Full-word writes only, and reads of VLED return the shadowed HELLO low half, not the masked LEDs
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module hello_regs (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  input  wire hello_pkg::reg_write_t    reg_write,
  input  wire logic [`HELLO_ADDR_W-1:0] rd_addr,
  output logic [`HELLO_DATA_W-1:0]      rd_data,
  output hello_pkg::cnt_ctrl_t          cnt_ctrl,
  input  wire hello_pkg::cnt_status_t   cnt_status,
  output logic [`HELLO_VLED_W-1:0]      vled_src
);

  logic [`HELLO_DATA_W-1:0] hello_q;
  logic [`HELLO_DATA_W-1:0] hello_swapped;
  logic [`HELLO_DATA_W-1:0] ctrl_rd;
  logic                     enable_q;
  logic                     oneshot_q;
  logic                     clear_q;
  logic                     load_q;
  logic [`HELLO_TICK_W-1:0] tick_value_q;
  logic [`HELLO_CNT_W-1:0]  load_value_q;
  logic [`HELLO_CNT_W-1:0]  watermark_q;
  logic                     wr_hello;
  logic                     wr_ctrl;
  logic                     wr_tick;
  logic                     wr_load;
  logic                     wr_wmark;

  // --------------------------------------------------------------------------
  // Write decode
  // --------------------------------------------------------------------------
  // VLED, CNT_STATUS and VERSION have no write hit
  assign wr_hello = reg_write.strobe && (reg_write.addr == hello_pkg::HELLO);
  assign wr_ctrl  = reg_write.strobe && (reg_write.addr == hello_pkg::CNT_CTRL);
  assign wr_tick  = reg_write.strobe && (reg_write.addr == hello_pkg::TICK_VALUE);
  assign wr_load  = reg_write.strobe && (reg_write.addr == hello_pkg::LOAD_VALUE);
  assign wr_wmark = reg_write.strobe && (reg_write.addr == hello_pkg::WATERMARK);

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      hello_q      <= '0;
      enable_q     <= 1'b0;
      oneshot_q    <= 1'b0;
      clear_q      <= 1'b0;
      load_q       <= 1'b0;
      tick_value_q <= '0;
      load_value_q <= '0;
      watermark_q  <= '0;
    end else begin
      if (wr_hello) begin
        hello_q <= reg_write.data;
      end
      // Level bits kept
      if (wr_ctrl) begin
        enable_q  <= reg_write.data[hello_pkg::CTRL_ENABLE_BIT];
        oneshot_q <= reg_write.data[hello_pkg::CTRL_ONESHOT_BIT];
      end
      // Pulse bits live for the one cycle after the write
      clear_q <= wr_ctrl && reg_write.data[hello_pkg::CTRL_CLEAR_BIT];
      load_q  <= wr_ctrl && reg_write.data[hello_pkg::CTRL_LOAD_BIT];
      if (wr_tick) begin
        tick_value_q <= reg_write.data[`HELLO_TICK_W-1:0];
      end
      if (wr_load) begin
        load_value_q <= reg_write.data[`HELLO_CNT_W-1:0];
      end
      if (wr_wmark) begin
        watermark_q <= reg_write.data[`HELLO_CNT_W-1:0];
      end
    end
  end

  // --------------------------------------------------------------------------
  // Read decode
  // --------------------------------------------------------------------------
  // HELLO returns bytes in reverse order
  assign hello_swapped = {hello_q[7:0], hello_q[15:8], hello_q[23:16], hello_q[31:24]};

  // Only the level bits read back
  always_comb begin
    ctrl_rd                               = '0;
    ctrl_rd[hello_pkg::CTRL_ENABLE_BIT]  = enable_q;
    ctrl_rd[hello_pkg::CTRL_ONESHOT_BIT] = oneshot_q;
  end

  always_comb begin
    case (rd_addr)
      hello_pkg::HELLO:      rd_data = hello_swapped;
      hello_pkg::VLED:       rd_data = {{(`HELLO_DATA_W-`HELLO_VLED_W){1'b0}}, vled_src};
      hello_pkg::CNT_CTRL:   rd_data = ctrl_rd;
      hello_pkg::TICK_VALUE: rd_data = {{(`HELLO_DATA_W-`HELLO_TICK_W){1'b0}}, tick_value_q};
      hello_pkg::LOAD_VALUE: rd_data = {{(`HELLO_DATA_W-`HELLO_CNT_W){1'b0}}, load_value_q};
      hello_pkg::WATERMARK:  rd_data = {{(`HELLO_DATA_W-`HELLO_CNT_W){1'b0}}, watermark_q};
      // Flag sits just above the count
      hello_pkg::CNT_STATUS: rd_data = {{(`HELLO_DATA_W-`HELLO_CNT_W-1){1'b0}},
                                        cnt_status.ge_watermark, cnt_status.count};
      hello_pkg::VERSION:    rd_data = `HELLO_VERSION;
      default:               rd_data = `HELLO_UNIMPL_VALUE;
    endcase
  end

  // Counter control bundle
  assign cnt_ctrl = '{
    enable:     enable_q,
    oneshot:    oneshot_q,
    clear:      clear_q,
    load:       load_q,
    tick_value: tick_value_q,
    load_value: load_value_q,
    watermark:  watermark_q
  };

  // LEDs shadow the low half of HELLO
  assign vled_src = hello_q[`HELLO_VLED_W-1:0];

  // Write spacing through the sequencer keeps pulses single-cycle
  a_clear_pulse: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    clear_q |=> !clear_q)
    else $error("counter clear held longer than one cycle");

  a_load_pulse: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    load_q |=> !load_q)
    else $error("counter load held longer than one cycle");

endmodule

`default_nettype wire

// ==== verilog/ocl_access_fsm.sv ====
// One host access in flight at a time, and a write presented with a read is always taken first
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module ocl_access_fsm (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  input  wire hello_pkg::ocl_wr_req_t   wr_req,
  output logic                          wr_ready,
  output logic                          bvalid,
  input  wire logic                     bready,
  input  wire hello_pkg::ocl_rd_req_t   rd_req,
  output logic                          rd_ready,
  output hello_pkg::ocl_rd_rsp_t        rd_rsp,
  input  wire logic                     rready,
  output hello_pkg::reg_write_t         reg_write,
  output logic [`HELLO_ADDR_W-1:0]      rd_addr,
  input  wire logic [`HELLO_DATA_W-1:0] rd_data
);

  hello_pkg::access_state_e state_q;
  hello_pkg::access_state_e state_d;
  logic [`HELLO_DATA_W-1:0] rd_data_q;
  logic                     wr_accept;
  logic                     rd_accept;

  // --------------------------------------------------------------------------
  // Request acceptance
  // --------------------------------------------------------------------------
  // Both readies only in IDLE
  assign wr_ready  = (state_q == hello_pkg::IDLE);
  // Read held off while a write is pending
  assign rd_ready  = (state_q == hello_pkg::IDLE) && !wr_req.valid;
  assign wr_accept = wr_req.valid && wr_ready;
  assign rd_accept = rd_req.valid && rd_ready;

  // Next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      hello_pkg::IDLE: begin
        if (wr_accept) begin
          state_d = hello_pkg::WRITE_RESP;
        end else if (rd_accept) begin
          state_d = hello_pkg::READ_RESP;
        end
      end
      // Wait for the host to take the response
      hello_pkg::WRITE_RESP: begin
        if (bready) begin
          state_d = hello_pkg::IDLE;
        end
      end
      hello_pkg::READ_RESP: begin
        if (rready) begin
          state_d = hello_pkg::IDLE;
        end
      end
      default: begin
        state_d = hello_pkg::IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      state_q <= hello_pkg::IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Read data sampled at the accept edge
  always_ff @(posedge clk_main_a0) begin
    if (rd_accept) begin
      rd_data_q <= rd_data;
    end
  end

  // --------------------------------------------------------------------------
  // Bank side and responses
  // --------------------------------------------------------------------------
  // Strobe in the accept cycle so the bank updates on the same edge as bvalid
  assign reg_write = '{strobe: wr_accept, addr: wr_req.addr, data: wr_req.data};
  assign rd_addr   = rd_req.addr;
  assign bvalid    = (state_q == hello_pkg::WRITE_RESP);
  assign rd_rsp    = '{valid: (state_q == hello_pkg::READ_RESP), data: rd_data_q};

  // Each response is raised only by an accept of its own kind
  a_bresp_src: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(bvalid) |-> $past(wr_accept))
    else $error("bvalid raised without a write accept");

  a_rresp_src: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    $rose(rd_rsp.valid) |-> $past(rd_accept))
    else $error("rd_rsp.valid raised without a read accept");

  // Responses hold until taken
  a_bresp_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  a_rresp_hold: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    rd_rsp.valid && !rready |=> rd_rsp.valid && $stable(rd_rsp.data))
    else $error("read response changed before rready");

endmodule

`default_nettype wire

// ==== verilog/tick_counter.sv ====
// Clear beats load and load beats a tick in the same cycle, and the prescaler runs only while enabled
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module tick_counter (
  input  wire logic                   clk_main_a0,
  input  wire logic                   rst_main_n_sync,
  input  wire hello_pkg::cnt_ctrl_t   cnt_ctrl,
  output hello_pkg::cnt_status_t      cnt_status
);

  logic [`HELLO_TICK_W-1:0] tick_cnt_q;
  logic [`HELLO_CNT_W-1:0]  count_q;
  logic                     tick;
  logic                     at_max;

  // --------------------------------------------------------------------------
  // Prescaler and event count
  // --------------------------------------------------------------------------
  // One tick every tick_value+1 enabled cycles
  assign tick   = cnt_ctrl.enable && (tick_cnt_q >= cnt_ctrl.tick_value);
  // Saturation point for one-shot
  assign at_max = (count_q == {`HELLO_CNT_W{1'b1}});

  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      tick_cnt_q <= '0;
      count_q    <= '0;
    end else if (cnt_ctrl.clear) begin
      tick_cnt_q <= '0;
      count_q    <= '0;
    end else begin
      // Prescaler frozen while disabled
      if (cnt_ctrl.enable) begin
        if (tick) begin
          tick_cnt_q <= '0;
        end else begin
          tick_cnt_q <= tick_cnt_q + 1'b1;
        end
      end
      // Load overrides a tick
      if (cnt_ctrl.load) begin
        count_q <= cnt_ctrl.load_value;
      end else if (tick && !(cnt_ctrl.oneshot && at_max)) begin
        // Wraps unless one-shot
        count_q <= count_q + 1'b1;
      end
    end
  end

  // Flag compares against the live watermark
  assign cnt_status = '{
    count:        count_q,
    ge_watermark: (count_q >= cnt_ctrl.watermark)
  };

  // One-shot holds at full scale
  a_oneshot_sat: assert property (@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
    cnt_ctrl.oneshot && !cnt_ctrl.clear && !cnt_ctrl.load && at_max
      |=> count_q != '0)
    else $error("one-shot counter wrapped from full scale");

endmodule

`default_nettype wire

// ==== verilog/vled_mask.sv ====
// vdip is treated as asynchronous and synchronized here, while vled_src must come from clk_main_a0
`timescale 1ns/1ns
`default_nettype none

`include "hello_defs.svh"

module vled_mask (
  input  wire logic                     clk_main_a0,
  input  wire logic                     rst_main_n_sync,
  input  wire logic [`HELLO_VLED_W-1:0] vled_src,
  input  wire logic [`HELLO_VLED_W-1:0] vdip,
  output logic [`HELLO_VLED_W-1:0]      vled
);

  logic [`HELLO_VLED_W-1:0] vdip_meta_q;
  logic [`HELLO_VLED_W-1:0] vdip_sync_q;
  logic [`HELLO_VLED_W-1:0] shadow_q;
  logic [`HELLO_VLED_W-1:0] vled_q;

  // --------------------------------------------------------------------------
  // Switch sync, LED shadow and masked output
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_main_a0) begin
    if (!rst_main_n_sync) begin
      vdip_meta_q <= '0;
      vdip_sync_q <= '0;
      shadow_q    <= '0;
      vled_q      <= '0;
    end else begin
      // Two-flop sync
      vdip_meta_q <= vdip;
      vdip_sync_q <= vdip_meta_q;
      // Shadow of HELLO low half
      shadow_q    <= vled_src;
      // Switches gate each LED
      vled_q      <= shadow_q & vdip_sync_q;
    end
  end

  assign vled = vled_q;

endmodule

`default_nettype wire
